//--- logic/busPort.sv
`timescale 1ns/1ps

module busPort import cachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic reqStart,
  input  logic reqWrite,
  input  addrT reqAddr,
  input  wordT reqData,
  output logic reqTaken,
  output logic busIdle,
  output logic respValid,
  output wordT respData,
  output logic memReqValid,
  output logic memReqWrite,
  output addrT memReqAddr,
  output wordT memReqData,
  input  logic memCredit,
  input  logic memRespValid,
  input  wordT memRespData
);

  creditT credits;
  logic   send;

  // Request goes out in the same cycle when a credit is free
  assign send        = reqStart && (credits != '0);
  assign reqTaken    = send;
  assign memReqValid = send;
  assign memReqWrite = reqWrite;
  assign memReqAddr  = reqAddr;
  assign memReqData  = reqData;

  // Read responses come back in order
  assign respValid = memRespValid;
  assign respData  = memRespData;

  // All credits home means every write was accepted
  assign busIdle = (credits == creditT'(maxCredits));

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      credits <= creditT'(maxCredits);
    end else begin
      case ({send, memCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        // Send and return together cancel out
        default: credits <= credits;
      endcase
    end
  end

endmodule

//--- logic/cacheController.sv
`timescale 1ns/1ps

module cacheController import cachePkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   cpuRead,
  input  logic   cpuWrite,
  input  logic   flush,
  input  addrT   cpuAddr,
  input  maskT   cpuMask,
  output logic   stall,
  input  logic   hit0,
  input  logic   hit1,
  input  logic   valid0,
  input  logic   valid1,
  input  logic   dirty0,
  input  logic   dirty1,
  input  tagT    tag0,
  input  tagT    tag1,
  input  wordT   line0Word,
  input  wordT   line1Word,
  output indexT  index,
  output offsetT wordSel,
  output tagT    lookupTag,
  output logic   wayWE0,
  output logic   wayWE1,
  output logic   fillTag0,
  output logic   fillTag1,
  output logic   setDirty0,
  output logic   setDirty1,
  output logic   clearDirty0,
  output logic   clearDirty1,
  output maskT   wayMask,
  output logic   useRespData,
  output logic   dataWay,
  output logic   reqStart,
  output logic   reqWrite,
  output addrT   reqAddr,
  output wordT   reqData,
  input  logic   reqTaken,
  input  logic   busIdle,
  input  logic   respValid
);

  ctrlState state, nextState;
  logic [numSets-1:0] lru;
  logic [offsetBits:0] reqCount, respCount;
  logic   curWay, flushing, flushDone, flushWay;
  indexT  flushSet;
  indexT  curIndex;
  tagT    curTag;
  offsetT curOff;
  tagT    wbTag;
  logic   access, hitAny, victimWay, victimDirty, lastResp, flushLast;

  assign curTag   = cpuAddr[31 -: tagBits];
  assign curIndex = cpuAddr[4 +: indexBits];
  assign curOff   = cpuAddr[2 +: offsetBits];

  assign access = cpuRead || cpuWrite;
  assign hitAny = hit0 || hit1;

  // Prefer an empty way, else the least recently used one
  assign victimWay   = !valid0 ? 1'b0 : (!valid1 ? 1'b1 : lru[curIndex]);
  assign victimDirty = victimWay ? dirty1 : dirty0;

  assign wbTag     = curWay ? tag1 : tag0;
  assign lastResp  = respValid && (respCount[offsetBits-1:0] == offsetT'(wordsPerLine - 1));
  assign flushLast = flushWay && (flushSet == indexT'(numSets - 1));

  assign index     = flushing ? flushSet : curIndex;
  assign lookupTag = curTag;
  assign reqData   = curWay ? line1Word : line0Word;

  always_comb begin
    nextState   = state;
    stall       = 1'b1;
    wordSel     = curOff;
    wayWE0      = 1'b0;
    wayWE1      = 1'b0;
    fillTag0    = 1'b0;
    fillTag1    = 1'b0;
    setDirty0   = 1'b0;
    setDirty1   = 1'b0;
    clearDirty0 = 1'b0;
    clearDirty1 = 1'b0;
    wayMask     = cpuMask;
    useRespData = 1'b0;
    dataWay     = curWay;
    reqStart    = 1'b0;
    reqWrite    = 1'b0;
    reqAddr     = {curTag, curIndex, reqCount[offsetBits-1:0], 2'b00};
    case (state)
      IDLE: begin
        dataWay = hit1;
        if (access) begin
          stall = !hitAny;
          if (hitAny) begin
            wayWE0    = cpuWrite && hit0;
            wayWE1    = cpuWrite && hit1;
            setDirty0 = cpuWrite && hit0;
            setDirty1 = cpuWrite && hit1;
          end else if (victimDirty) begin
            nextState = WRITEBACK;
          end else begin
            nextState = REFILL;
          end
        end else if (flush && !flushDone) begin
          nextState = FLUSHSCAN;
        end else begin
          stall = 1'b0;
        end
      end
      WRITEBACK: begin
        // Stream the old line out word by word
        wordSel  = reqCount[offsetBits-1:0];
        reqStart = 1'b1;
        reqWrite = 1'b1;
        reqAddr  = {wbTag, index, reqCount[offsetBits-1:0], 2'b00};
        if (reqTaken && reqCount[offsetBits-1:0] == offsetT'(wordsPerLine - 1)) begin
          clearDirty0 = !curWay;
          clearDirty1 = curWay;
          nextState   = WBDRAIN;
        end
      end
      WBDRAIN: begin
        if (busIdle) begin
          nextState = flushing ? FLUSHNEXT : REFILL;
        end
      end
      REFILL: begin
        reqStart    = !reqCount[offsetBits];
        wordSel     = respCount[offsetBits-1:0];
        wayMask     = '1;
        useRespData = 1'b1;
        wayWE0      = respValid && !curWay;
        wayWE1      = respValid && curWay;
        if (lastResp) begin
          fillTag0  = !curWay;
          fillTag1  = curWay;
          nextState = IDLE;
        end
      end
      FLUSHSCAN: begin
        nextState = (flushWay ? dirty1 : dirty0) ? WRITEBACK : FLUSHNEXT;
      end
      FLUSHNEXT: begin
        nextState = flushLast ? IDLE : FLUSHSCAN;
      end
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      lru       <= '0;
      reqCount  <= '0;
      respCount <= '0;
      curWay    <= 1'b0;
      flushing  <= 1'b0;
      flushDone <= 1'b0;
      flushSet  <= '0;
      flushWay  <= 1'b0;
    end else begin
      state <= nextState;

      // Word counters restart between bursts
      if (state == IDLE || state == FLUSHSCAN || state == WBDRAIN) begin
        reqCount  <= '0;
        respCount <= '0;
      end else begin
        if (reqTaken) begin
          reqCount <= reqCount + 1'b1;
        end
        if (respValid && state == REFILL) begin
          respCount <= respCount + 1'b1;
        end
      end

      if (state == IDLE && access) begin
        if (hitAny) begin
          lru[curIndex] <= hit0;
        end else begin
          curWay <= victimWay;
        end
      end
      if (state == REFILL && lastResp) begin
        lru[curIndex] <= !curWay;
      end

      // Flush walks every set and way in order
      if (state == IDLE && nextState == FLUSHSCAN) begin
        flushing <= 1'b1;
        flushSet <= '0;
        flushWay <= 1'b0;
      end
      if (state == FLUSHSCAN) begin
        curWay <= flushWay;
      end
      if (state == FLUSHNEXT) begin
        {flushSet, flushWay} <= {flushSet, flushWay} + 1'b1;
        if (flushLast) begin
          flushing <= 1'b0;
        end
      end

      // Held until the flush request drops
      if (!flush) begin
        flushDone <= 1'b0;
      end else if (state == FLUSHNEXT && flushLast) begin
        flushDone <= 1'b1;
      end
    end
  end

endmodule

//--- logic/cachePkg.sv
package cachePkg;

  // Cache geometry
  localparam int numSets = 16;
  localparam int wordsPerLine = 4;

  // Address fields: tag 31:8, index 7:4, word offset 3:2, byte offset 1:0
  localparam int offsetBits = 2;
  localparam int indexBits = 4;
  localparam int tagBits = 24;

  // Outstanding memory requests allowed at once
  localparam int maxCredits = 2;

  typedef logic [31:0] addrT;
  typedef logic [31:0] wordT;
  typedef logic [3:0] maskT;
  typedef logic [tagBits-1:0] tagT;
  typedef logic [indexBits-1:0] indexT;
  typedef logic [offsetBits-1:0] offsetT;
  typedef logic [1:0] creditT;

  // Controller FSM states
  typedef enum logic [2:0] {
    IDLE,
    WRITEBACK,
    WBDRAIN,
    REFILL,
    FLUSHSCAN,
    FLUSHNEXT
  } ctrlState;

endpackage

//--- logic/cacheWay.sv
`timescale 1ns/1ps

module cacheWay import cachePkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  indexT  index,
  input  offsetT wordSel,
  input  tagT    lookupTag,
  input  logic   wordWE,
  input  maskT   wordMask,
  input  wordT   wordIn,
  input  logic   fillTag,
  input  logic   setDirty,
  input  logic   clearDirty,
  output logic   hit,
  output logic   valid,
  output logic   dirty,
  output tagT    storedTag,
  output wordT   wordOut
);

  wordT dataArr [numSets][wordsPerLine];
  tagT  tagArr [numSets];
  logic [numSets-1:0] validBits;
  logic [numSets-1:0] dirtyBits;

  // Asynchronous read of the addressed set
  assign storedTag = tagArr[index];
  assign valid     = validBits[index];
  assign dirty     = dirtyBits[index];
  assign hit       = valid && (storedTag == lookupTag);
  assign wordOut   = dataArr[index][wordSel];

  // Data and tag storage
  always_ff @(posedge clk) begin
    if (wordWE) begin
      for (int b = 0; b < $bits(maskT); b++) begin
        if (wordMask[b]) begin
          dataArr[index][wordSel][8*b +: 8] <= wordIn[8*b +: 8];
        end
      end
    end
    if (fillTag) begin
      tagArr[index] <= lookupTag;
    end
  end

  // Line state bits
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      validBits <= '0;
      dirtyBits <= '0;
    end else begin
      if (fillTag) begin
        validBits[index] <= 1'b1;
      end
      // A fresh line starts clean
      if (fillTag || clearDirty) begin
        dirtyBits[index] <= 1'b0;
      end else if (setDirty) begin
        dirtyBits[index] <= 1'b1;
      end
    end
  end

endmodule

//--- logic/dataCache.sv
`timescale 1ns/1ps

module dataCache import cachePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic cpuRead,
  input  logic cpuWrite,
  input  addrT cpuAddr,
  input  wordT cpuWData,
  input  maskT cpuMask,
  input  logic flush,
  output wordT cpuRData,
  output logic stall,
  output logic memReqValid,
  output logic memReqWrite,
  output addrT memReqAddr,
  output wordT memReqData,
  input  logic memCredit,
  input  logic memRespValid,
  input  wordT memRespData
);

  indexT  index;
  offsetT wordSel;
  tagT    lookupTag, tag0, tag1;
  maskT   wayMask;
  wordT   line0Word, line1Word, wayData, reqData, respData;
  addrT   reqAddr;
  logic   hit0, hit1, valid0, valid1, dirty0, dirty1;
  logic   wayWE0, wayWE1, fillTag0, fillTag1;
  logic   setDirty0, setDirty1, clearDirty0, clearDirty1;
  logic   useRespData, dataWay;
  logic   reqStart, reqWrite, reqTaken, busIdle, respValid;

  // Refill data comes from the bus, store data from the processor
  assign wayData  = useRespData ? respData : cpuWData;
  assign cpuRData = dataWay ? line1Word : line0Word;

  cacheWay way0 (
    .clk(clk), .reset(reset), .index(index), .wordSel(wordSel),
    .lookupTag(lookupTag), .wordWE(wayWE0), .wordMask(wayMask), .wordIn(wayData),
    .fillTag(fillTag0), .setDirty(setDirty0), .clearDirty(clearDirty0),
    .hit(hit0), .valid(valid0), .dirty(dirty0), .storedTag(tag0), .wordOut(line0Word)
  );

  cacheWay way1 (
    .clk(clk), .reset(reset), .index(index), .wordSel(wordSel),
    .lookupTag(lookupTag), .wordWE(wayWE1), .wordMask(wayMask), .wordIn(wayData),
    .fillTag(fillTag1), .setDirty(setDirty1), .clearDirty(clearDirty1),
    .hit(hit1), .valid(valid1), .dirty(dirty1), .storedTag(tag1), .wordOut(line1Word)
  );

  cacheController ctrl (
    .clk(clk), .reset(reset), .cpuRead(cpuRead), .cpuWrite(cpuWrite), .flush(flush),
    .cpuAddr(cpuAddr), .cpuMask(cpuMask), .stall(stall),
    .hit0(hit0), .hit1(hit1), .valid0(valid0), .valid1(valid1),
    .dirty0(dirty0), .dirty1(dirty1), .tag0(tag0), .tag1(tag1),
    .line0Word(line0Word), .line1Word(line1Word),
    .index(index), .wordSel(wordSel), .lookupTag(lookupTag),
    .wayWE0(wayWE0), .wayWE1(wayWE1), .fillTag0(fillTag0), .fillTag1(fillTag1),
    .setDirty0(setDirty0), .setDirty1(setDirty1),
    .clearDirty0(clearDirty0), .clearDirty1(clearDirty1),
    .wayMask(wayMask), .useRespData(useRespData), .dataWay(dataWay),
    .reqStart(reqStart), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqData(reqData),
    .reqTaken(reqTaken), .busIdle(busIdle), .respValid(respValid)
  );

  busPort port (
    .clk(clk), .reset(reset), .reqStart(reqStart), .reqWrite(reqWrite),
    .reqAddr(reqAddr), .reqData(reqData), .reqTaken(reqTaken), .busIdle(busIdle),
    .respValid(respValid), .respData(respData),
    .memReqValid(memReqValid), .memReqWrite(memReqWrite),
    .memReqAddr(memReqAddr), .memReqData(memReqData),
    .memCredit(memCredit), .memRespValid(memRespValid), .memRespData(memRespData)
  );

endmodule

//--- tests/dataCacheSva.sv
`timescale 1ns/1ps

module dataCacheSva import cachePkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   memReqValid,
  input logic   memCredit,
  input creditT credits
);

  int inFlight;
  int failCount = 0;

  // Requests sent on the bus and not yet credited back
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      inFlight <= 0;
    end else begin
      inFlight <= inFlight + int'(memReqValid) - int'(memCredit);
    end
  end

  // A new request needs a credit that memory has not yet used up
  property reqNeedsCredit;
    @(posedge clk) disable iff (reset) memReqValid |-> (inFlight < maxCredits);
  endproperty

  // Credit pool bounded by its reset value
  property creditsBounded;
    @(posedge clk) disable iff (reset) credits <= creditT'(maxCredits);
  endproperty

  // Bus is quiet in the first cycle out of reset
  property quietAfterReset;
    @(posedge clk) $fell(reset) |-> !memReqValid;
  endproperty

  assert property (reqNeedsCredit) else begin
    failCount++;
    $error("memReqValid high with zero credits");
  end
  assert property (creditsBounded) else begin
    failCount++;
    $error("credit count above maxCredits");
  end
  assert property (quietAfterReset) else begin
    failCount++;
    $error("memReqValid high right after reset");
  end

endmodule

bind busPort dataCacheSva busSva (
  .clk(clk), .reset(reset), .memReqValid(memReqValid), .memCredit(memCredit),
  .credits(credits)
);

//--- tests/dataCacheTb.sv
`timescale 1ns/1ps

module dataCacheTb import cachePkg::*; ();

  localparam int timeoutCycles = 2000;
  localparam int regionWords = 256;

  logic clk = 1'b0;
  logic reset, cpuRead, cpuWrite, flush, stall;
  addrT cpuAddr, memReqAddr;
  wordT cpuWData, cpuRData, memReqData, memRespData;
  maskT cpuMask;
  logic memReqValid, memReqWrite, memCredit, memRespValid;

  // Memory model, shadow memory and pending bus events
  wordT memArr [regionWords];
  wordT shadow [regionWords];
  wordT respQ [$];
  int creditDue [$];
  int respDue [$];
  logic [64:0] reqLog [$];
  int cycle = 0;
  int outstanding = 0;
  int lastCreditDue = 0;
  int lastRespDue = 0;
  int valueErrors = 0;
  int otherErrors = 0;
  int svaErrors = 0;
  bit slowCredits = 1'b0;
  integer seed = 61;

  // Tag model that predicts the bus traffic of each access
  tagT mTag [numSets][2];
  logic [1:0] mValid [numSets];
  logic [1:0] mDirty [numSets];
  logic [numSets-1:0] mLru;

  dataCache i_dut (.*);

  always #4 clk = ~clk;

  task automatic compareValue(input string name, input logic [64:0] expVal,
                              input logic [64:0] gotVal);
    assert (gotVal === expVal) else begin
      valueErrors++;
      $display("ERR %0t %s exp %h got %h", $time, name, expVal, gotVal);
    end
  endtask

  task automatic expectTrue(input bit cond, input string what);
    assert (cond) else begin
      otherErrors++;
      $display("%0t: %s", $time, what);
    end
  endtask

  function automatic int dueCycle(input int lastDue, input int delay);
    return (cycle + delay > lastDue) ? cycle + delay : lastDue + 1;
  endfunction

  // Memory takes requests at the rising edge
  always @(posedge clk) begin
    if (memReqValid) begin
      expectTrue(outstanding < maxCredits, "request sent with no credit left");
      if (memReqWrite) begin
        memArr[memReqAddr[9:2]] = memReqData;
        reqLog.push_back({1'b1, memReqAddr, memReqData});
      end else begin
        respQ.push_back(memArr[memReqAddr[9:2]]);
        lastRespDue = dueCycle(lastRespDue, 1 + {$random(seed)} % 4);
        respDue.push_back(lastRespDue);
        reqLog.push_back({1'b0, memReqAddr, 32'h0});
      end
      lastCreditDue = dueCycle(lastCreditDue, 1 + {$random(seed)} % 3 + (slowCredits ? 6 : 0));
      creditDue.push_back(lastCreditDue);
      outstanding++;
    end
    if (memCredit) begin
      outstanding--;
    end
  end

  // At most one credit and one response per cycle, in order
  always @(negedge clk) begin
    cycle++;
    memCredit = 1'b0;
    memRespValid = 1'b0;
    if (creditDue.size() > 0 && creditDue[0] <= cycle) begin
      void'(creditDue.pop_front());
      memCredit = 1'b1;
    end
    if (respDue.size() > 0 && respDue[0] <= cycle) begin
      void'(respDue.pop_front());
      memRespData = respQ.pop_front();
      memRespValid = 1'b1;
    end
  end

  task automatic waitReady(output int cycles, output wordT rdata);
    bit stalled;
    cycles = 0;
    do begin
      @(posedge clk);
      stalled = stall;
      rdata = cpuRData;
      cycles++;
    end while (stalled && cycles < timeoutCycles);
    if (stalled) begin
      $display("Timeout: stall still high after %0d cycles", cycles);
      $display("Checks failed");
      $finish;
    end
  endtask

  task automatic accessCache(input logic wr, input addrT a, input wordT d, input maskT m);
    logic [64:0] expLog [$];
    indexT idx;
    tagT tg;
    addrT lineAddr;
    int way, victim, cycles;
    bit wasHit;
    wordT got;
    idx = a[7:4];
    tg = a[31:8];
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (mValid[idx][w] && mTag[idx][w] == tg) begin
        way = w;
      end
    end
    wasHit = (way >= 0);
    if (!wasHit) begin
      if (!mValid[idx][0]) begin
        victim = 0;
      end else if (!mValid[idx][1]) begin
        victim = 1;
      end else begin
        victim = int'(mLru[idx]);
      end
      // Dirty victim words leave before any refill read
      if (mValid[idx][victim] && mDirty[idx][victim]) begin
        for (int w = 0; w < wordsPerLine; w++) begin
          lineAddr = {mTag[idx][victim], idx, offsetT'(w), 2'b00};
          expLog.push_back({1'b1, lineAddr, shadow[lineAddr[9:2]]});
        end
      end
      for (int w = 0; w < wordsPerLine; w++) begin
        lineAddr = {tg, idx, offsetT'(w), 2'b00};
        expLog.push_back({1'b0, lineAddr, 32'h0});
      end
      mTag[idx][victim] = tg;
      mValid[idx][victim] = 1'b1;
      mDirty[idx][victim] = 1'b0;
      way = victim;
    end
    mLru[idx] = (way == 0);
    if (wr) begin
      mDirty[idx][way] = 1'b1;
    end

    @(negedge clk);
    cpuRead = !wr;
    cpuWrite = wr;
    cpuAddr = a;
    cpuWData = d;
    cpuMask = m;
    waitReady(cycles, got);
    @(negedge clk);
    cpuRead = 1'b0;
    cpuWrite = 1'b0;
    if (!wr) begin
      compareValue("cpuRData", 65'(shadow[a[9:2]]), 65'(got));
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (m[b]) begin
          shadow[a[9:2]][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    expectTrue(!wasHit || cycles == 1, "hit did not complete in the first cycle");
    expectTrue(reqLog.size() == expLog.size(), "wrong number of memory requests for an access");
    for (int i = 0; i < expLog.size() && i < reqLog.size(); i++) begin
      compareValue("memReq", expLog[i], reqLog[i]);
    end
    reqLog.delete();
  endtask

  task automatic flushCache();
    int cycles, expWrites;
    wordT unused;
    expWrites = 0;
    for (int s = 0; s < numSets; s++) begin
      expWrites += 4 * $countones(mDirty[s]);
    end
    @(negedge clk);
    flush = 1'b1;
    waitReady(cycles, unused);
    @(negedge clk);
    flush = 1'b0;
    expectTrue(reqLog.size() == expWrites, "flush sent the wrong number of write requests");
    for (int i = 0; i < reqLog.size(); i++) begin
      expectTrue(reqLog[i][64], "flush sent a read request");
    end
    for (int i = 0; i < regionWords; i++) begin
      compareValue("memArr", 65'(shadow[i]), 65'(memArr[i]));
    end
    for (int s = 0; s < numSets; s++) begin
      mDirty[s] = '0;
    end
    reqLog.delete();
  endtask

  initial begin
    logic wr;
    addrT a;
    wordT d;
    maskT m;
    reset = 1'b1;
    {cpuRead, cpuWrite, flush, memCredit, memRespValid} = '0;
    cpuAddr = '0;
    cpuWData = '0;
    cpuMask = '0;
    memRespData = '0;
    mLru = '0;
    for (int s = 0; s < numSets; s++) begin
      mValid[s] = '0;
      mDirty[s] = '0;
    end
    for (int i = 0; i < regionWords; i++) begin
      memArr[i] = wordT'(i) * 32'h9e37_79b1 + 32'h1357_2468;
      shadow[i] = memArr[i];
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Three tags in set 5, then the dirty LRU line gets evicted
    accessCache(1'b1, 32'h050, 32'h1111_1111, 4'hf);
    accessCache(1'b1, 32'h154, 32'h2222_2222, 4'h3);
    accessCache(1'b0, 32'h058, 32'h0, 4'h0);
    accessCache(1'b0, 32'h25c, 32'h0, 4'h0);
    accessCache(1'b0, 32'h154, 32'h0, 4'h0);

    for (int n = 0; n < 600; n++) begin
      slowCredits = (n >= 300 && n < 400);
      wr = 1'($random(seed));
      a = $random(seed);
      d = $random(seed);
      m = 4'($random(seed));
      accessCache(wr, {22'h0, a[9:2], 2'b00}, d, m);
      if (n % 150 == 149) begin
        flushCache();
      end
    end
    // Second flush finds nothing dirty
    flushCache();
    flushCache();

    svaErrors = i_dut.port.busSva.failCount;
    $display("Errors: %0d value, %0d other, %0d assertion",
             valueErrors, otherErrors, svaErrors);
    if (valueErrors + otherErrors + svaErrors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/cachePkg.sv
logic/cacheWay.sv
logic/busPort.sv
logic/cacheController.sv
logic/dataCache.sv
tests/dataCacheSva.sv
tests/dataCacheTb.sv
